// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_sdmac
FILELIST = filelist.f
LOG      = sim.log
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q ">>> PASS" $(LOG) || (echo "simulation failed" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: dma_engine.sv
`timescale 1ns/1ps
`default_nettype none

module dma_engine (
    input  wire logic                 CLK,
    input  wire logic                 _AS,
    input  wire sdmac_pkg::dma_cmd_t  dma_cmd,
    output sdmac_pkg::dma_stat_t      dma_stat,
    input  wire logic                 word_valid,
    input  wire logic [31:0]          word_data,
    output logic                      word_pop,
    input  wire logic                 fifo_full,
    input  wire logic                 fifo_empty,
    output sdmac_pkg::wb_req_t        mem_req,
    input  wire sdmac_pkg::wb_rsp_t   mem_rsp,
    output logic                      irq
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT_WORD,
        ST_BUS_WRITE
    } state_t;

    state_t      state_q;
    logic [23:0] count_q;                 // Words still to move
    logic [31:0] addr_q;
    logic [31:0] wdata_q;
    logic        tc_q;
    logic        stop_pend_q;             // Stop seen during a bus cycle

    logic        go;
    logic        wr_done;

    assign go      = dma_cmd.start && dma_cmd.cntr.dma_enable && (dma_cmd.wtc != 24'h0);
    assign wr_done = (state_q == ST_BUS_WRITE) && mem_rsp.ack;
    assign word_pop = wr_done;            // Head word leaves the FIFO on ack

    always_ff @(posedge CLK or posedge _AS) begin
        if (_AS) begin
            state_q     <= ST_IDLE;
            count_q     <= '0;
            addr_q      <= '0;
            tc_q        <= 1'b0;
            stop_pend_q <= 1'b0;
        end else begin
            if (dma_cmd.clr_int) begin
                tc_q <= 1'b0;
            end

            case (state_q)
                ST_IDLE: begin
                    stop_pend_q <= 1'b0;
                    if (go) begin
                        count_q <= dma_cmd.wtc;
                        addr_q  <= dma_cmd.acr;
                        state_q <= ST_WAIT_WORD;
                    end
                end

                ST_WAIT_WORD: begin
                    if (dma_cmd.stop) begin
                        state_q <= ST_IDLE;
                    end else if (word_valid) begin
                        state_q <= ST_BUS_WRITE;
                    end
                end

                ST_BUS_WRITE: begin
                    if (dma_cmd.stop) begin
                        stop_pend_q <= 1'b1;
                    end
                    if (wr_done) begin
                        count_q <= count_q - 24'd1;
                        addr_q  <= addr_q + 32'd4;
                        if (count_q == 24'd1) begin
                            tc_q    <= 1'b1;   // Last word written
                            state_q <= ST_IDLE;
                        end else if (stop_pend_q || dma_cmd.stop) begin
                            state_q <= ST_IDLE;
                        end else begin
                            state_q <= ST_WAIT_WORD;
                        end
                    end
                end

                default: state_q <= ST_IDLE;
            endcase
        end
    end

    // Bus data held steady for the whole write cycle
    always_ff @(posedge CLK) begin
        if ((state_q == ST_WAIT_WORD) && word_valid) begin
            wdata_q <= word_data;
        end
    end

    always_comb begin
        mem_req.cyc = (state_q == ST_BUS_WRITE);
        mem_req.stb = (state_q == ST_BUS_WRITE);
        mem_req.we  = (state_q == ST_BUS_WRITE);
        mem_req.adr = addr_q;
        mem_req.dat = wdata_q;
    end

    always_comb begin
        dma_stat.istr.reserved       = 4'h0;
        dma_stat.istr.int_pending    = tc_q & dma_cmd.cntr.tc_int_enable;
        dma_stat.istr.terminal_count = tc_q;
        dma_stat.istr.dma_active     = (state_q != ST_IDLE);
        dma_stat.istr.fifo_full      = fifo_full;
        dma_stat.istr.fifo_empty     = fifo_empty;
        dma_stat.count               = count_q;
        dma_stat.addr                = addr_q;
    end

    assign irq = dma_stat.istr.int_pending;

endmodule

`default_nettype wire

// File: filelist.f
sdmac_pkg.sv
sdmac_regs.sv
scsi_fifo.sv
dma_engine.sv
sdmac_top.sv
sdmac_checker.sv
tb_sdmac.sv

// File: scsi_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module scsi_fifo #(
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic                  CLK,
    input  wire logic                  _AS,
    input  wire sdmac_pkg::scsi_byte_t scsi_in,
    output logic                       scsi_ready,
    input  wire logic                  flush,
    input  wire logic                  word_pop,
    output logic                       word_valid,
    output logic [31:0]                word_data,
    output logic                       fifo_full,
    output logic                       fifo_empty
);

    localparam int AW = $clog2(FIFO_DEPTH);

    logic [23:0] pack_q;                  // Earlier bytes of the current word
    logic [1:0]  nbytes_q;                // Bytes held in pack_q
    logic [AW:0] wr_ptr_q;                // Extra bit tells full from empty
    logic [AW:0] rd_ptr_q;
    logic [31:0] buf_q [FIFO_DEPTH];

    logic        take;
    logic        push;
    logic        pop;

    assign fifo_empty = (wr_ptr_q == rd_ptr_q);
    assign fifo_full  = (wr_ptr_q[AW] != rd_ptr_q[AW]) &&
                        (wr_ptr_q[AW-1:0] == rd_ptr_q[AW-1:0]);

    // Stall only a fourth byte with nowhere to go
    assign scsi_ready = !(fifo_full && (nbytes_q == 2'd3));
    assign take       = scsi_in.valid && scsi_ready;
    assign push       = take && (nbytes_q == 2'd3);
    assign pop        = word_pop && !fifo_empty;

    assign word_valid = !fifo_empty;
    assign word_data  = buf_q[rd_ptr_q[AW-1:0]];

    always_ff @(posedge CLK or posedge _AS) begin
        if (_AS) begin
            nbytes_q <= '0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else if (flush) begin
            // Buffer and partial word both dropped
            nbytes_q <= '0;
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
        end else begin
            if (take) begin
                nbytes_q <= nbytes_q + 2'd1;    // Wraps after the fourth byte
            end
            if (push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
        end
    end

    // Big-endian packing, first byte ends up in [31:24]
    always_ff @(posedge CLK) begin
        if (take) begin
            pack_q <= {pack_q[15:0], scsi_in.data};
        end
        if (push && !flush) begin
            buf_q[wr_ptr_q[AW-1:0]] <= {pack_q, scsi_in.data};
        end
    end

endmodule

`default_nettype wire

// File: sdmac_checker.sv
`timescale 1ns/1ps
`default_nettype none

module sdmac_checker (
    input wire logic               CLK,
    input wire logic               _AS,
    input wire sdmac_pkg::wb_req_t cpu_req,
    input wire sdmac_pkg::wb_rsp_t cpu_rsp,
    input wire sdmac_pkg::wb_req_t mem_req,
    input wire sdmac_pkg::wb_rsp_t mem_rsp,
    input wire logic               irq
);

    string       test_name = "none";
    int          errors = 0;
    int          errors_at_start = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    logic [31:0] rd_exp [$];              // Expected CPU read data, in order
    logic [63:0] wr_exp [$];              // Expected {adr, dat} of memory writes
    logic        cur_we = 1'b0;
    logic [31:0] exp_rd;
    logic [63:0] exp_wr;

    task automatic report_mismatch(input string what, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("error %s %s expected %h actual %h", test_name, what, exp, act);
        errors++;
    endtask

    task automatic note_failure(input string what);
        $display("test %s: %s", test_name, what);
        errors++;
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic end_test();
        if (rd_exp.size() != 0) note_failure("expected CPU reads never happened");
        if (wr_exp.size() != 0) note_failure("expected memory writes never happened");
        rd_exp.delete();
        wr_exp.delete();
        if (errors == errors_at_start) begin
            $display("test %s: ok", test_name);
            tests_passed++;
        end else begin
            $display("test %s: %0d errors", test_name, errors - errors_at_start);
            tests_failed++;
        end
    endtask

    task automatic expect_read(input logic [31:0] exp);
        rd_exp.push_back(exp);
    endtask

    task automatic expect_write(input logic [31:0] adr, input logic [31:0] dat);
        wr_exp.push_back({adr, dat});
    endtask

    task automatic check_irq(input logic exp);
        if (irq !== exp) report_mismatch("irq", 64'(exp), 64'(irq));
    endtask

    always @(posedge CLK) begin
        if (!_AS) begin
            if (cpu_req.cyc && cpu_req.stb && !cpu_rsp.ack) begin
                cur_we = cpu_req.we;      // Direction of the cycle in flight
            end
            if (cpu_rsp.ack && !cur_we) begin
                if (rd_exp.size() == 0) begin
                    note_failure("CPU read with no expected value");
                end else begin
                    exp_rd = rd_exp.pop_front();
                    if (cpu_rsp.dat !== exp_rd) begin
                        report_mismatch("read", 64'(exp_rd), 64'(cpu_rsp.dat));
                    end
                end
            end
            if (mem_req.cyc && mem_req.stb && mem_rsp.ack) begin
                if (mem_req.we !== 1'b1) begin
                    report_mismatch("mem we", 64'h1, 64'(mem_req.we));
                end
                if (wr_exp.size() == 0) begin
                    note_failure("unexpected memory write");
                end else begin
                    exp_wr = wr_exp.pop_front();
                    if ({mem_req.adr, mem_req.dat} !== exp_wr) begin
                        report_mismatch("mem write", exp_wr, {mem_req.adr, mem_req.dat});
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: sdmac_pkg.sv
`default_nettype none

package sdmac_pkg;

    // Word offsets, CPU address bits [6:2]
    localparam logic [4:0] REG_DAWR   = 5'h00;
    localparam logic [4:0] REG_WTC    = 5'h01;
    localparam logic [4:0] REG_CNTR   = 5'h02;
    localparam logic [4:0] REG_ACR    = 5'h03;
    localparam logic [4:0] REG_ST_DMA = 5'h04;
    localparam logic [4:0] REG_FLUSH  = 5'h05;
    localparam logic [4:0] REG_CINT   = 5'h06;
    localparam logic [4:0] REG_ISTR   = 5'h07;
    localparam logic [4:0] REG_TEST   = 5'h08;
    localparam logic [4:0] REG_SP_DMA = 5'h0F;

    localparam logic [31:0] TEST_RESET = 32'h5555_5555;

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        logic [3:0] spare;           // Stored only
        logic       tc_int_enable;   // Bit 1
        logic       dma_enable;      // Bit 0
    } cntr_t;

    typedef struct packed {
        logic [3:0] reserved;
        logic       int_pending;     // Bit 4
        logic       terminal_count;
        logic       dma_active;
        logic       fifo_full;
        logic       fifo_empty;      // Bit 0
    } istr_t;

    // Register block to engine
    typedef struct packed {
        logic        start;
        logic        stop;
        logic        flush;
        logic        clr_int;
        cntr_t       cntr;
        logic [23:0] wtc;
        logic [31:0] acr;
    } dma_cmd_t;

    // Engine to register block, live counters
    typedef struct packed {
        istr_t       istr;
        logic [23:0] count;
        logic [31:0] addr;
    } dma_stat_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] data;
    } scsi_byte_t;

endpackage

`default_nettype wire

// File: sdmac_regs.sv
`timescale 1ns/1ps
`default_nettype none

module sdmac_regs (
    input  wire logic                 CLK,
    input  wire logic                 _AS,
    input  wire sdmac_pkg::wb_req_t   cpu_req,
    output sdmac_pkg::wb_rsp_t        cpu_rsp,
    input  wire sdmac_pkg::dma_stat_t dma_stat,
    output sdmac_pkg::dma_cmd_t       dma_cmd
);

    logic [4:0]       offs;
    logic             access;
    logic             ack_q;
    logic [31:0]      rdata_q;
    logic [31:0]      rd_mux;

    logic [1:0]       dawr_q;
    logic [23:0]      wtc_q;
    sdmac_pkg::cntr_t cntr_q;
    logic [31:0]      acr_q;
    logic [31:0]      test_q;

    // Set once the engine has run, cleared by a CPU write
    logic             wtc_live_q;
    logic             acr_live_q;

    logic             start_q;
    logic             stop_q;
    logic             flush_q;
    logic             cint_q;

    assign offs   = cpu_req.adr[6:2];
    assign access = cpu_req.cyc & cpu_req.stb & ~ack_q;   // First cycle of a bus cycle

    always_comb begin
        case (offs)
            sdmac_pkg::REG_WTC:
                rd_mux = wtc_live_q ? {8'h00, dma_stat.count} : {8'h00, wtc_q};
            sdmac_pkg::REG_CNTR:
                rd_mux = {26'h0, cntr_q};
            sdmac_pkg::REG_ACR:
                rd_mux = acr_live_q ? dma_stat.addr : acr_q;
            sdmac_pkg::REG_ISTR:
                rd_mux = {23'h0, dma_stat.istr};
            sdmac_pkg::REG_TEST:
                rd_mux = test_q;
            default:
                rd_mux = 32'h0;                            // DAWR, strobes, unlisted
        endcase
    end

    always_ff @(posedge CLK or posedge _AS) begin
        if (_AS) begin
            ack_q      <= 1'b0;
            start_q    <= 1'b0;
            stop_q     <= 1'b0;
            flush_q    <= 1'b0;
            cint_q     <= 1'b0;
            dawr_q     <= '0;
            wtc_q      <= '0;
            cntr_q     <= '0;
            acr_q      <= '0;
            test_q     <= sdmac_pkg::TEST_RESET;
            wtc_live_q <= 1'b0;
            acr_live_q <= 1'b0;
        end else begin
            ack_q   <= access;
            // Read or write both fire the strobe
            start_q <= access && (offs == sdmac_pkg::REG_ST_DMA);
            stop_q  <= access && (offs == sdmac_pkg::REG_SP_DMA);
            flush_q <= access && (offs == sdmac_pkg::REG_FLUSH);
            cint_q  <= access && (offs == sdmac_pkg::REG_CINT);

            if (dma_stat.istr.dma_active) begin
                wtc_live_q <= 1'b1;
                acr_live_q <= 1'b1;
            end

            if (access && cpu_req.we) begin
                case (offs)
                    sdmac_pkg::REG_DAWR: dawr_q <= cpu_req.dat[1:0];
                    sdmac_pkg::REG_WTC: begin
                        wtc_q      <= cpu_req.dat[23:0];
                        wtc_live_q <= 1'b0;
                    end
                    sdmac_pkg::REG_CNTR: cntr_q <= cpu_req.dat[5:0];
                    sdmac_pkg::REG_ACR: begin
                        acr_q      <= cpu_req.dat;
                        acr_live_q <= 1'b0;
                    end
                    sdmac_pkg::REG_TEST: test_q <= cpu_req.dat;
                    default: ;                             // ISTR and unlisted ignored
                endcase
            end
        end
    end

    // Read data lines up with ack
    always_ff @(posedge CLK) begin
        if (access) begin
            rdata_q <= rd_mux;
        end
    end

    always_comb begin
        cpu_rsp.ack = ack_q;
        cpu_rsp.dat = rdata_q;
    end

    always_comb begin
        dma_cmd.start   = start_q;
        dma_cmd.stop    = stop_q;
        dma_cmd.flush   = flush_q;
        dma_cmd.clr_int = cint_q;
        dma_cmd.cntr    = cntr_q;
        dma_cmd.wtc     = wtc_q;
        dma_cmd.acr     = acr_q;
    end

endmodule

`default_nettype wire

// File: sdmac_top.sv
`timescale 1ns/1ps
`default_nettype none

module sdmac_top #(
    parameter int FIFO_DEPTH = 4          // Words, power of two
) (
    input  wire logic                  CLK,
    input  wire logic                  _AS,
    input  wire sdmac_pkg::wb_req_t    cpu_req,
    output sdmac_pkg::wb_rsp_t         cpu_rsp,
    input  wire sdmac_pkg::scsi_byte_t scsi_in,
    output logic                       scsi_ready,
    output sdmac_pkg::wb_req_t         mem_req,
    input  wire sdmac_pkg::wb_rsp_t    mem_rsp,
    output logic                       irq
);

    sdmac_pkg::dma_cmd_t  dma_cmd;
    sdmac_pkg::dma_stat_t dma_stat;

    logic        word_valid;
    logic [31:0] word_data;
    logic        word_pop;
    logic        fifo_full;
    logic        fifo_empty;

    sdmac_regs u_regs (
        .CLK      (CLK),
        ._AS      (_AS),
        .cpu_req  (cpu_req),
        .cpu_rsp  (cpu_rsp),
        .dma_stat (dma_stat),
        .dma_cmd  (dma_cmd)
    );

    scsi_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .CLK        (CLK),
        ._AS        (_AS),
        .scsi_in    (scsi_in),
        .scsi_ready (scsi_ready),
        .flush      (dma_cmd.flush),
        .word_pop   (word_pop),
        .word_valid (word_valid),
        .word_data  (word_data),
        .fifo_full  (fifo_full),
        .fifo_empty (fifo_empty)
    );

    dma_engine u_engine (
        .CLK        (CLK),
        ._AS        (_AS),
        .dma_cmd    (dma_cmd),
        .dma_stat   (dma_stat),
        .word_valid (word_valid),
        .word_data  (word_data),
        .word_pop   (word_pop),
        .fifo_full  (fifo_full),
        .fifo_empty (fifo_empty),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .irq        (irq)
    );

endmodule

`default_nettype wire

// File: tb_sdmac.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sdmac;

    localparam int FIFO_DEPTH   = 4;
    localparam int MAX_ACCESSES = 60;     // CPU accesses over all tests
    localparam int MAX_BYTES    = 70;     // SCSI bytes over all tests
    localparam int MAX_WORDS    = 20;     // Memory writes over all tests
    localparam int CYCLE_LIMIT  = 16 + MAX_ACCESSES * 4 + MAX_BYTES * 6 + MAX_WORDS * 8 + 500;

    logic                  CLK;
    logic                  _AS;
    sdmac_pkg::wb_req_t    cpu_req;
    sdmac_pkg::wb_rsp_t    cpu_rsp;
    sdmac_pkg::scsi_byte_t scsi_in;
    logic                  scsi_ready;
    sdmac_pkg::wb_req_t    mem_req;
    sdmac_pkg::wb_rsp_t    mem_rsp;
    logic                  irq;

    integer      seed;
    int          cycles = 0;
    int          mem_writes;
    int          wait_left;
    logic [31:0] mem [logic [31:0]];      // Memory slave storage
    logic [7:0]  bytes_q [$];             // Sent bytes not yet packed
    logic [31:0] r;
    logic [31:0] a;
    int          n;
    int          base;

    sdmac_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) dut (
        .CLK        (CLK),
        ._AS        (_AS),
        .cpu_req    (cpu_req),
        .cpu_rsp    (cpu_rsp),
        .scsi_in    (scsi_in),
        .scsi_ready (scsi_ready),
        .mem_req    (mem_req),
        .mem_rsp    (mem_rsp),
        .irq        (irq)
    );

    sdmac_checker chk (
        .CLK     (dut.CLK),
        ._AS     (dut._AS),
        .cpu_req (dut.cpu_req),
        .cpu_rsp (dut.cpu_rsp),
        .mem_req (dut.mem_req),
        .mem_rsp (dut.mem_rsp),
        .irq     (dut.irq)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run stopped at the cycle limit of %0d", CYCLE_LIMIT);
            $display(">>> FAIL");
            $finish;
        end
    end

    // Memory slave, 0 to 3 wait states, one-cycle ack
    always @(negedge CLK) begin
        if (mem_rsp.ack) begin
            mem_rsp.ack = 1'b0;
        end else if (mem_req.cyc && mem_req.stb) begin
            if (wait_left == 0) begin
                mem_rsp.ack = 1'b1;
                mem[mem_req.adr] = mem_req.dat;
                mem_writes++;
                wait_left = next_wait();
            end else begin
                wait_left--;
            end
        end
    end

    function automatic int next_wait();
        logic [31:0] w;
        w = $random(seed);
        return int'(w[1:0]);
    endfunction

    task automatic cpu_access(input logic [4:0] offs, input logic we, input logic [31:0] data);
        int tries;
        cpu_req.cyc = 1'b1;
        cpu_req.stb = 1'b1;
        cpu_req.we  = we;
        cpu_req.adr = {25'h0, offs, 2'b00};
        cpu_req.dat = data;
        tries = 0;
        @(negedge CLK);
        while (!cpu_rsp.ack && tries < 8) begin
            @(negedge CLK);
            tries++;
        end
        if (!cpu_rsp.ack) begin
            chk.note_failure("no ack from the register block");
        end
        cpu_req.cyc = 1'b0;
        cpu_req.stb = 1'b0;
        @(negedge CLK);                   // stb low for a cycle
    endtask

    task automatic cpu_write(input logic [4:0] offs, input logic [31:0] data);
        cpu_access(offs, 1'b1, data);
    endtask

    task automatic cpu_read(input logic [4:0] offs, input logic [31:0] exp);
        chk.expect_read(exp);
        cpu_access(offs, 1'b0, 32'h0);
    endtask

    task automatic send_bytes(input int count);
        logic [31:0] rb;
        int tries;
        for (int i = 0; i < count; i++) begin
            rb = $random(seed);
            repeat (int'(rb[9:8])) @(negedge CLK);   // Random gap
            bytes_q.push_back(rb[7:0]);
            scsi_in.valid = 1'b1;
            scsi_in.data  = rb[7:0];
            tries = 0;
            while (!scsi_ready && tries < 100) begin
                @(negedge CLK);
                tries++;
            end
            if (!scsi_ready) begin
                chk.note_failure("SCSI byte never accepted");
            end
            @(negedge CLK);
            scsi_in.valid = 1'b0;
        end
    endtask

    // Big-endian words from the oldest sent bytes
    task automatic expect_words(input int count, input logic [31:0] addr);
        logic [31:0] w;
        for (int i = 0; i < count; i++) begin
            w = {bytes_q[0], bytes_q[1], bytes_q[2], bytes_q[3]};
            repeat (4) void'(bytes_q.pop_front());
            chk.expect_write(addr + 32'(4 * i), w);
        end
    endtask

    task automatic wait_writes(input int target);
        int tries;
        tries = 0;
        while (mem_writes < target && tries < 400) begin
            @(negedge CLK);
            tries++;
        end
        if (mem_writes < target) begin
            chk.note_failure("memory writes did not arrive");
        end
        @(negedge CLK);
    endtask

    task automatic run_transfer(input int words, input logic [31:0] addr, input logic [5:0] ctl);
        int start_count;
        cpu_write(sdmac_pkg::REG_WTC, 32'(words));
        cpu_write(sdmac_pkg::REG_ACR, addr);
        cpu_write(sdmac_pkg::REG_CNTR, {26'h0, ctl});
        send_bytes(4 * words);
        expect_words(words, addr);
        start_count = mem_writes;
        cpu_read(sdmac_pkg::REG_ST_DMA, 32'h0);
        wait_writes(start_count + words);
    endtask

    initial begin
        seed       = 32'h39317a81;
        _AS        = 1'b1;
        cpu_req    = '0;
        scsi_in    = '0;
        mem_rsp    = '0;
        wait_left  = 0;
        mem_writes = 0;
        repeat (16) @(negedge CLK);
        _AS = 1'b0;
        @(negedge CLK);

        chk.begin_test("reset");
        cpu_read(sdmac_pkg::REG_TEST, 32'h5555_5555);
        cpu_read(sdmac_pkg::REG_WTC, 32'h0);
        cpu_read(sdmac_pkg::REG_CNTR, 32'h0);
        cpu_read(sdmac_pkg::REG_ACR, 32'h0);
        cpu_read(sdmac_pkg::REG_ISTR, 32'h1);    // fifo_empty only
        cpu_read(sdmac_pkg::REG_DAWR, 32'h0);
        chk.end_test();

        chk.begin_test("registers");
        r = $random(seed);
        cpu_write(sdmac_pkg::REG_WTC, r);
        cpu_read(sdmac_pkg::REG_WTC, {8'h0, r[23:0]});
        r = $random(seed);
        cpu_write(sdmac_pkg::REG_CNTR, r);
        cpu_read(sdmac_pkg::REG_CNTR, {26'h0, r[5:0]});
        r = $random(seed);
        cpu_write(sdmac_pkg::REG_ACR, r);
        cpu_read(sdmac_pkg::REG_ACR, r);
        r = $random(seed);
        cpu_write(sdmac_pkg::REG_TEST, r);
        cpu_read(sdmac_pkg::REG_TEST, r);
        cpu_write(sdmac_pkg::REG_ISTR, $random(seed));
        cpu_read(sdmac_pkg::REG_ISTR, 32'h1);
        cpu_write(5'h0A, $random(seed));
        cpu_read(5'h0A, 32'h0);
        cpu_read(sdmac_pkg::REG_TEST, r);        // Unchanged by the writes above
        chk.end_test();

        chk.begin_test("transfer");
        r = $random(seed);
        n = 1 + int'(r[1:0]);
        a = {r[31:2], 2'b00};
        run_transfer(n, a, 6'h03);
        cpu_read(sdmac_pkg::REG_WTC, 32'h0);
        cpu_read(sdmac_pkg::REG_ACR, a + 32'(4 * n));
        cpu_read(sdmac_pkg::REG_ISTR, 32'h19);   // int_pending, terminal_count, empty
        chk.check_irq(1'b1);
        chk.end_test();

        chk.begin_test("interrupt");
        cpu_read(sdmac_pkg::REG_CINT, 32'h0);
        chk.check_irq(1'b0);
        cpu_read(sdmac_pkg::REG_ISTR, 32'h1);
        r = $random(seed);
        n = 1 + int'(r[1:0]);
        run_transfer(n, {r[31:2], 2'b00}, 6'h01);
        chk.check_irq(1'b0);
        cpu_read(sdmac_pkg::REG_ISTR, 32'h09);   // terminal_count without int_pending
        cpu_read(sdmac_pkg::REG_CINT, 32'h0);
        chk.end_test();

        chk.begin_test("flush_stop");
        r = $random(seed);
        send_bytes(4 * (1 + int'(r[0])) + 2);    // At least one whole word buffered
        cpu_read(sdmac_pkg::REG_FLUSH, 32'h0);
        bytes_q.delete();
        cpu_read(sdmac_pkg::REG_ISTR, 32'h1);
        n = 1 + int'(r[2:1]);
        run_transfer(n, {r[31:3], 3'b000}, 6'h03);
        cpu_read(sdmac_pkg::REG_WTC, 32'h0);
        cpu_read(sdmac_pkg::REG_CINT, 32'h0);
        a = $random(seed);
        a[1:0] = 2'b00;
        cpu_write(sdmac_pkg::REG_WTC, 32'd4);
        cpu_write(sdmac_pkg::REG_ACR, a);
        cpu_write(sdmac_pkg::REG_CNTR, 32'h1);
        send_bytes(8);
        expect_words(2, a);
        base = mem_writes;
        cpu_read(sdmac_pkg::REG_ST_DMA, 32'h0);
        wait_writes(base + 2);                   // Engine now starved for a word
        cpu_read(sdmac_pkg::REG_SP_DMA, 32'h0);
        cpu_read(sdmac_pkg::REG_ISTR, 32'h1);
        cpu_read(sdmac_pkg::REG_WTC, 32'd2);
        cpu_read(sdmac_pkg::REG_ACR, a + 32'd8);
        chk.end_test();

        $display("tests passed %0d failed %0d", chk.tests_passed, chk.tests_failed);
        if (chk.tests_failed == 0 && chk.errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
